/* include/bridge_params.svh */
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// ******************************
// address windows
// ******************************

// timer: ctrl, preset, count
`define BRIDGE_TIMER_LB 32'h0000_7f00
`define BRIDGE_TIMER_UB 32'h0000_7f0b

// gpio: leds, switches, keys
`define BRIDGE_GPIO_LB 32'h0000_7f10
`define BRIDGE_GPIO_UB 32'h0000_7f1b

// ******************************
// gpio widths
// ******************************

// led output register
`define LED_W 16

// dip switches, synchronized before use
`define SW_W 16

// push buttons, active high
`define KEY_W 4

`endif

/* verilog/bus_pkg.sv */
`default_nettype none

package bus_pkg;

	// ******************************
	// cpu side
	// ******************************

	typedef struct packed {
		logic [31:0] addr;
		logic        we;    // write strobe, one edge
		logic [31:0] wdata;
	} bus_req_t;

	// ******************************
	// device side
	// ******************************

	typedef struct packed {
		logic        sel;    // address falls in this window
		logic        we;     // already gated by sel
		logic [1:0]  offset; // word index inside the window
		logic [31:0] wdata;
	} dev_req_t;

	typedef enum logic [1:0] {
		DEV_TIMER = 2'd0,
		DEV_GPIO  = 2'd1,
		DEV_NONE  = 2'd2
	} dev_sel_e;

endpackage

`default_nettype wire

/* verilog/dev_pkg.sv */
`default_nettype none

package dev_pkg;

	// ******************************
	// timer
	// ******************************

	typedef enum logic [1:0] {
		MODE_ONESHOT = 2'd0,
		MODE_RELOAD  = 2'd1
	} timer_mode_e;

	typedef enum logic [1:0] {
		T_IDLE  = 2'd0,
		T_LOAD  = 2'd1,
		T_COUNT = 2'd2,
		T_IRQ   = 2'd3
	} timer_state_e;

	typedef struct packed {
		logic [27:0] rsvd;     // reads zero
		logic        irq_mask;
		timer_mode_e mode;
		logic        enable;
	} timer_ctrl_t;

	typedef enum logic [1:0] {
		TMR_CTRL   = 2'd0,
		TMR_PRESET = 2'd1,
		TMR_COUNT  = 2'd2
	} timer_reg_e;

	// ******************************
	// gpio
	// ******************************

	typedef enum logic [1:0] {
		GPIO_LED = 2'd0,
		GPIO_SW  = 2'd1,
		GPIO_KEY = 2'd2 // pending bits, write 1 to clear
	} gpio_reg_e;

endpackage

`default_nettype wire

/* verilog/timer.sv */
`timescale 1ns/1ps
`default_nettype none

module timer (
	input  logic              clk,
	input  logic              rst_n,
	input  bus_pkg::dev_req_t req,
	output logic [31:0]       rdata,
	output logic              irq
);
	import dev_pkg::*;

	timer_ctrl_t  ctrl;
	logic [31:0]  preset;
	logic [31:0]  count;
	timer_state_e state;
	timer_state_e state_nxt;
	timer_reg_e   reg_sel;
	logic         ctrl_wr;
	logic         preset_wr;
	logic         oneshot;
	logic         irq_entry;

	assign reg_sel   = timer_reg_e'(req.offset);
	assign ctrl_wr   = req.sel && req.we && (reg_sel == TMR_CTRL);
	assign preset_wr = req.sel && req.we && (reg_sel == TMR_PRESET);
	assign oneshot   = (ctrl.mode != MODE_RELOAD); // unused encodings act as one-shot
	assign irq_entry = (state_nxt == T_IRQ) && (state != T_IRQ);

	// ******************************
	// state machine
	// ******************************

	always_comb begin
		state_nxt = state;
		if (ctrl_wr) begin
			state_nxt = req.wdata[0] ? T_LOAD : T_IDLE; // any ctrl write restarts
		end else begin
			case (state)
				T_LOAD: begin
					state_nxt = (preset == '0) ? T_IRQ : T_COUNT;
				end
				T_COUNT: begin
					if (count == 32'd1) begin
						state_nxt = T_IRQ; // this edge takes count to zero
					end
				end
				T_IRQ: begin
					if (!oneshot) begin
						state_nxt = T_LOAD; // one cycle of irq, then reload
					end
				end
				default: begin
					state_nxt = state;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state  <= T_IDLE;
			ctrl   <= '0;
			preset <= '0;
			count  <= '0;
		end else begin
			state <= state_nxt;
			if (preset_wr) begin
				preset <= req.wdata;
			end
			if (ctrl_wr) begin
				ctrl.enable   <= req.wdata[0];
				ctrl.mode     <= timer_mode_e'(req.wdata[2:1]);
				ctrl.irq_mask <= req.wdata[3];
			end else if (irq_entry && oneshot) begin
				ctrl.enable <= 1'b0;
			end
			if (!ctrl_wr) begin
				if (state == T_LOAD) begin
					count <= preset;
				end else if (state == T_COUNT) begin
					count <= count - 32'd1;
				end
			end
		end
	end

	// ******************************
	// read port and irq
	// ******************************

	always_comb begin
		rdata = '0;
		if (req.sel) begin
			case (reg_sel)
				TMR_CTRL:   rdata = ctrl;
				TMR_PRESET: rdata = preset;
				TMR_COUNT:  rdata = count;
				default:    rdata = '0; // offset 3
			endcase
		end
	end

	assign irq = (state == T_IRQ) && ctrl.irq_mask;

	// irq only once the count has run out
	a_irq_state: assert property (
		@(posedge clk) disable iff (!rst_n)
		irq |-> (state == T_IRQ) && (count == '0)
	);

	// counting is strictly downward
	a_count_down: assert property (
		@(posedge clk) disable iff (!rst_n)
		($past(state) == T_COUNT) && (state == T_COUNT) |-> (count < $past(count))
	);

endmodule

`default_nettype wire

/* verilog/gpio.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bridge_params.svh"

module gpio (
	input  logic              clk,
	input  logic              rst_n,
	input  bus_pkg::dev_req_t req,
	input  logic [`SW_W-1:0]  switches,
	input  logic [`KEY_W-1:0] keys,
	output logic [31:0]       rdata,
	output logic [`LED_W-1:0] leds,
	output logic              irq
);
	import dev_pkg::*;

	gpio_reg_e         reg_sel;
	logic              led_wr;
	logic              key_wr;
	logic [`SW_W-1:0]  sw_meta;
	logic [`SW_W-1:0]  sw_sync;
	logic [`KEY_W-1:0] key_meta;
	logic [`KEY_W-1:0] key_sync;
	logic [`KEY_W-1:0] key_hist;
	logic [`KEY_W-1:0] key_rise;
	logic [`KEY_W-1:0] key_clr;
	logic [`KEY_W-1:0] pending;

	assign reg_sel  = gpio_reg_e'(req.offset);
	assign led_wr   = req.sel && req.we && (reg_sel == GPIO_LED);
	assign key_wr   = req.sel && req.we && (reg_sel == GPIO_KEY);
	assign key_rise = key_sync & ~key_hist;
	assign key_clr  = key_wr ? req.wdata[`KEY_W-1:0] : '0;

	// ******************************
	// registers
	// ******************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			leds     <= '0;
			sw_meta  <= '0;
			sw_sync  <= '0;
			key_meta <= '0;
			key_sync <= '0;
			key_hist <= '0;
			pending  <= '0;
		end else begin
			if (led_wr) begin
				leds <= req.wdata[`LED_W-1:0];
			end
			sw_meta  <= switches;
			sw_sync  <= sw_meta;
			key_meta <= keys;
			key_sync <= key_meta;
			key_hist <= key_sync;
			pending  <= (pending & ~key_clr) | key_rise; // a new press beats a clear
		end
	end

	// ******************************
	// read port and irq
	// ******************************

	always_comb begin
		rdata = '0;
		if (req.sel) begin
			case (reg_sel)
				GPIO_LED: rdata = 32'(leds);
				GPIO_SW:  rdata = 32'(sw_sync);
				GPIO_KEY: rdata = 32'(pending);
				default:  rdata = '0;
			endcase
		end
	end

	assign irq = |pending;

	// every newly pending bit comes from a synchronized press
	a_pending_src: assert property (
		@(posedge clk) disable iff (!rst_n)
		((pending & ~$past(pending)) & ~($past(key_sync) & ~$past(key_sync, 2))) == '0
	);

endmodule

`default_nettype wire

/* verilog/bridge.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bridge_params.svh"

module bridge (
	input  logic              clk,
	input  logic              rst_n,
	input  bus_pkg::bus_req_t bus,
	output bus_pkg::dev_req_t timer_req,
	output bus_pkg::dev_req_t gpio_req,
	input  logic [31:0]       timer_rdata,
	input  logic [31:0]       gpio_rdata,
	input  logic              timer_irq,
	input  logic              gpio_irq,
	output logic [31:0]       rdata,
	output logic [5:0]        hwirq
);
	import bus_pkg::*;

	dev_sel_e    dev_sel;
	logic        in_timer;
	logic        in_gpio;
	logic [31:0] timer_off;
	logic [31:0] gpio_off;

	// ******************************
	// address decode
	// ******************************

	assign in_timer = ($unsigned(bus.addr) >= $unsigned(`BRIDGE_TIMER_LB)) &&
		($unsigned(bus.addr) <= $unsigned(`BRIDGE_TIMER_UB));
	assign in_gpio  = ($unsigned(bus.addr) >= $unsigned(`BRIDGE_GPIO_LB)) &&
		($unsigned(bus.addr) <= $unsigned(`BRIDGE_GPIO_UB));

	always_comb begin
		if (in_timer) begin
			dev_sel = DEV_TIMER;
		end else if (in_gpio) begin
			dev_sel = DEV_GPIO;
		end else begin
			dev_sel = DEV_NONE; // writes here are dropped
		end
	end

	assign timer_off = bus.addr - `BRIDGE_TIMER_LB;
	assign gpio_off  = bus.addr - `BRIDGE_GPIO_LB;

	// ******************************
	// device requests
	// ******************************

	always_comb begin
		timer_req.sel    = (dev_sel == DEV_TIMER);
		timer_req.we     = bus.we && timer_req.sel;
		timer_req.offset = timer_off[3:2]; // byte to word index
		timer_req.wdata  = bus.wdata;

		gpio_req.sel    = (dev_sel == DEV_GPIO);
		gpio_req.we     = bus.we && gpio_req.sel;
		gpio_req.offset = gpio_off[3:2];
		gpio_req.wdata  = bus.wdata;
	end

	// ******************************
	// read mux and interrupts
	// ******************************

	always_comb begin
		case (dev_sel)
			DEV_TIMER: rdata = timer_rdata;
			DEV_GPIO:  rdata = gpio_rdata;
			default:   rdata = '0;
		endcase
	end

	assign hwirq = {4'b0, gpio_irq, timer_irq};

	// windows must not overlap
	a_one_hot_sel: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(in_timer && in_gpio)
	);

endmodule

`default_nettype wire

/* verilog/io_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bridge_params.svh"

module io_subsystem (
	input  logic              clk,
	input  logic              rst_n,
	input  bus_pkg::bus_req_t bus,
	input  logic [`SW_W-1:0]  switches,
	input  logic [`KEY_W-1:0] keys,
	output logic [31:0]       rdata,
	output logic [5:0]        hwirq,
	output logic [`LED_W-1:0] leds
);
	import bus_pkg::*;

	dev_req_t    timer_req;
	dev_req_t    gpio_req;
	logic [31:0] timer_rdata;
	logic [31:0] gpio_rdata;
	logic        timer_irq;
	logic        gpio_irq;

	bridge bridge (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus),
		.timer_req(timer_req),
		.gpio_req(gpio_req),
		.timer_rdata(timer_rdata),
		.gpio_rdata(gpio_rdata),
		.timer_irq(timer_irq),
		.gpio_irq(gpio_irq),
		.rdata(rdata),
		.hwirq(hwirq)
	);

	timer timer (
		.clk(clk),
		.rst_n(rst_n),
		.req(timer_req),
		.rdata(timer_rdata),
		.irq(timer_irq)
	);

	gpio gpio (
		.clk(clk),
		.rst_n(rst_n),
		.req(gpio_req),
		.switches(switches),
		.keys(keys),
		.rdata(gpio_rdata),
		.leds(leds),
		.irq(gpio_irq)
	);

endmodule

`default_nettype wire

/* tb/tb_io_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bridge_params.svh"

module tb_io_subsystem;
	import bus_pkg::*;
	import dev_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] UNMAPPED_ADDR = 32'h0000_7f20;
	localparam logic [31:0] GAP_ADDR = 32'h0000_7f0c; // between the two windows
	localparam int RUN_CYCLES = 8 + 10 + 50 + 30 + 50 + 60 + 80; // reset, then tests 1 to 6
	localparam int MARGIN_CYCLES = 100;

	logic              clk;
	logic              rst_n;
	bus_req_t          bus;
	logic [`SW_W-1:0]  switches;
	logic [`KEY_W-1:0] keys;
	logic [31:0]       rdata;
	logic [5:0]        hwirq;
	logic [`LED_W-1:0] leds;

	logic [31:0] lfsr;
	int          checks;
	int          data_errors;
	int          irq_errors;

	io_subsystem dut (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus),
		.switches(switches),
		.keys(keys),
		.rdata(rdata),
		.hwirq(hwirq),
		.leds(leds)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ******************************
	// helpers
	// ******************************

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[0];
			lfsr = (lfsr >> 1) ^ (b ? LFSR_TAPS : 32'h0); // galois step, one per bit
			r = {r[30:0], b};
		end
		return r;
	endfunction

	function automatic logic [31:0] reg_addr(input logic [31:0] base, input logic [1:0] offset);
		return base + {28'b0, offset, 2'b00};
	endfunction

	// enable bit 0, mode bits 2:1, mask bit 3
	function automatic logic [31:0] ctrl_word(input logic en, input logic [1:0] mode,
		input logic mask);
		return {28'b0, mask, mode, en};
	endfunction

	task automatic check_data(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			data_errors++;
			$display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_irq(input string name, input logic [5:0] got, input logic [5:0] exp);
		checks++;
		if (got !== exp) begin
			irq_errors++;
			$display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
		@(negedge clk);
		bus.addr = addr;
		bus.we = 1'b1;
		bus.wdata = data;
		@(negedge clk); // write edge has passed
		bus.we = 1'b0;
		bus.wdata = '0;
	endtask

	task automatic expect_read(input string name, input logic [31:0] addr,
		input logic [31:0] exp);
		@(negedge clk);
		bus.addr = addr;
		bus.we = 1'b0;
		#1;
		check_data(name, rdata, exp);
	endtask

	// ******************************
	// tests
	// ******************************

	task automatic test_reset_values();
		for (int i = 0; i < 3; i++) begin
			expect_read("timer rdata", reg_addr(`BRIDGE_TIMER_LB, i[1:0]), '0);
			expect_read("gpio rdata", reg_addr(`BRIDGE_GPIO_LB, i[1:0]), '0);
		end
		check_irq("hwirq", hwirq, '0);
	endtask

	task automatic test_leds();
		logic [31:0] data;
		logic [31:0] led_exp;
		for (int i = 0; i < 6; i++) begin
			data = rand_bits(32);
			led_exp = data & ((32'd1 << `LED_W) - 32'd1);
			bus_write(reg_addr(`BRIDGE_GPIO_LB, GPIO_LED), data);
			expect_read("gpio led", reg_addr(`BRIDGE_GPIO_LB, GPIO_LED), led_exp);
			check_data("leds", 32'(leds), led_exp);
			bus_write(UNMAPPED_ADDR, ~data); // must be dropped
			expect_read("unmapped rdata", UNMAPPED_ADDR, '0);
			expect_read("gpio led", reg_addr(`BRIDGE_GPIO_LB, GPIO_LED), led_exp);
			check_data("leds", 32'(leds), led_exp);
		end
		expect_read("gap rdata", GAP_ADDR, '0);
	endtask

	task automatic test_switches();
		logic [31:0]      r;
		logic [`SW_W-1:0] sw;
		for (int i = 0; i < 8; i++) begin
			r = rand_bits(`SW_W);
			sw = r[`SW_W-1:0];
			@(negedge clk);
			switches = sw;
			bus.addr = reg_addr(`BRIDGE_GPIO_LB, GPIO_SW);
			repeat (2) @(negedge clk); // two sync flops
			#1;
			check_data("gpio sw", rdata, 32'(sw));
		end
	endtask

	task automatic test_oneshot();
		int p;
		p = 3 + int'(rand_bits(3));
		bus_write(reg_addr(`BRIDGE_TIMER_LB, TMR_PRESET), 32'(p));
		expect_read("timer preset", reg_addr(`BRIDGE_TIMER_LB, TMR_PRESET), 32'(p));
		bus_write(reg_addr(`BRIDGE_TIMER_LB, TMR_CTRL), ctrl_word(1'b1, MODE_ONESHOT, 1'b1));
		for (int k = 0; k <= p + 3; k++) begin // k edges after the ctrl write
			#1;
			check_irq("hwirq", hwirq, (k >= p + 1) ? 6'b000001 : 6'b000000);
			@(negedge clk);
		end
		expect_read("timer count", reg_addr(`BRIDGE_TIMER_LB, TMR_COUNT), '0);
		expect_read("timer ctrl", reg_addr(`BRIDGE_TIMER_LB, TMR_CTRL),
			ctrl_word(1'b0, MODE_ONESHOT, 1'b1));

		// masked run
		bus_write(reg_addr(`BRIDGE_TIMER_LB, TMR_CTRL), ctrl_word(1'b1, MODE_ONESHOT, 1'b0));
		for (int k = 0; k <= p + 3; k++) begin
			#1;
			check_irq("hwirq", hwirq, '0);
			@(negedge clk);
		end
		expect_read("timer count", reg_addr(`BRIDGE_TIMER_LB, TMR_COUNT), '0);
		expect_read("timer ctrl", reg_addr(`BRIDGE_TIMER_LB, TMR_CTRL),
			ctrl_word(1'b0, MODE_ONESHOT, 1'b0));
	endtask

	task automatic test_reload();
		int p;
		int c;
		p = 2 + int'(rand_bits(3));
		bus_write(reg_addr(`BRIDGE_TIMER_LB, TMR_PRESET), 32'(p));
		bus_write(reg_addr(`BRIDGE_TIMER_LB, TMR_CTRL), ctrl_word(1'b1, MODE_RELOAD, 1'b1));
		bus.addr = reg_addr(`BRIDGE_TIMER_LB, TMR_COUNT);
		for (int k = 0; k <= 3 * (p + 2) + 1; k++) begin
			#1;
			if (k >= 1) begin
				c = (k - 1) % (p + 2); // position in the reload period
				check_irq("hwirq", hwirq, (c == p) ? 6'b000001 : 6'b000000);
				check_data("timer count", rdata, (c <= p) ? 32'(p - c) : 32'd0);
			end
			@(negedge clk);
		end
		bus_write(reg_addr(`BRIDGE_TIMER_LB, TMR_CTRL), '0); // stop
		for (int k = 0; k < p + 2; k++) begin // a whole period without a pulse
			#1;
			check_irq("hwirq", hwirq, '0);
			@(negedge clk);
		end
	endtask

	task automatic test_keys();
		logic [31:0] bit_mask;
		for (int i = 0; i < `KEY_W; i++) begin
			bit_mask = 32'd1 << i;
			@(negedge clk);
			keys = bit_mask[`KEY_W-1:0];
			for (int k = 1; k <= 4; k++) begin
				@(negedge clk);
				#1;
				check_irq("hwirq", hwirq, (k >= 3) ? 6'b000010 : 6'b000000);
			end
			expect_read("gpio key", reg_addr(`BRIDGE_GPIO_LB, GPIO_KEY), bit_mask);
			bus_write(reg_addr(`BRIDGE_GPIO_LB, GPIO_KEY), bit_mask);
			for (int k = 0; k < 6; k++) begin // key still held
				#1;
				check_irq("hwirq", hwirq, '0);
				check_data("gpio key", rdata, '0);
				@(negedge clk);
			end
			keys = '0;
			repeat (4) @(negedge clk);
			#1;
			check_irq("hwirq", hwirq, '0);
		end
	endtask

	// ******************************
	// run
	// ******************************

	initial begin
		#(CLK_PERIOD * (RUN_CYCLES + MARGIN_CYCLES));
		$display("timeout: tests did not finish within %0d cycles",
			RUN_CYCLES + MARGIN_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		lfsr = 32'hf7ea_78aa;
		checks = 0;
		data_errors = 0;
		irq_errors = 0;
		rst_n = 1'b0;
		bus = '0;
		switches = '0;
		keys = '0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		test_reset_values();
		test_leds();
		test_switches();
		test_oneshot();
		test_reload();
		test_keys();

		$display("checks: %0d, data errors: %0d, irq errors: %0d",
			checks, data_errors, irq_errors);
		if (data_errors + irq_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* io_subsystem.f */
+incdir+include
verilog/bus_pkg.sv
verilog/dev_pkg.sv
verilog/timer.sv
verilog/gpio.sv
verilog/bridge.sv
verilog/io_subsystem.sv
tb/tb_io_subsystem.sv

/* Makefile */
TOP := tb_io_subsystem

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f io_subsystem.f --top-module $(TOP) \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qx '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log
